/* design/cluster_route_pkg.sv */
package cluster_route_pkg;

	typedef logic [15:0] word_t;     // raw table word
	typedef logic [15:0] fix_q_t;    // q value, 11.5
	typedef logic [15:0] fix_batt_t; // battery level, 1.15
	typedef logic [15:0] fix_hcm_t;  // hop count multiplier, 3.13
	typedef logic [10:0] mem_addr_t; // byte address into table ram
	typedef logic [12:0] axi_addr_t;
	typedef logic [31:0] axi_data_t;

	typedef enum logic [3:0] {
		idle,
		read_sink_count,
		read_neighbor_count,
		check_cluster,
		check_battery,
		check_q,
		write_better,
		read_hcm,
		read_neighbor_id,
		scan_sinks,
		read_best_id,
		write_count,
		finish
	} eval_state_t;

	// table layout, little-endian words
	localparam mem_addr_t known_sinks_base      = 11'h008;
	localparam mem_addr_t neighbor_id_base      = 11'h048;
	localparam mem_addr_t cluster_id_base       = 11'h0C8;
	localparam mem_addr_t battery_base          = 11'h148;
	localparam mem_addr_t q_value_base          = 11'h1C8;
	localparam mem_addr_t hcm_base              = 11'h648;
	localparam mem_addr_t better_list_base      = 11'h668;
	localparam mem_addr_t known_sink_count_addr = 11'h688;
	localparam mem_addr_t neighbor_count_addr   = 11'h68A;
	localparam mem_addr_t better_count_addr     = 11'h68C;
	localparam int        mem_depth             = 2048;

	localparam int unsigned hcm_length        = 11;
	localparam fix_batt_t   battery_threshold = 16'h0147; // ~0.01
	localparam word_t       no_hop            = 16'd65;   // no hop found yet
	localparam fix_q_t      worst_value       = 16'hFFFE;

	// host register map, anything below mem_window_end is the ram
	localparam axi_addr_t mem_window_end       = 13'h0800;
	localparam axi_addr_t reg_ctrl             = 13'h1000;
	localparam axi_addr_t reg_cluster_id       = 13'h1004;
	localparam axi_addr_t reg_my_best          = 13'h1008;
	localparam axi_addr_t reg_status           = 13'h1010;
	localparam axi_addr_t reg_best_hop         = 13'h1014;
	localparam axi_addr_t reg_best_value       = 13'h1018;
	localparam axi_addr_t reg_best_neighbor_id = 13'h101C;
	localparam axi_addr_t reg_next_sink        = 13'h1020;

endpackage

/* design/neighbor_table_ram.sv */
`timescale 1ns/10ps

module neighbor_table_ram
	import cluster_route_pkg::*;
(
	input  logic      clock,
	// port a, host side, registered read
	input  mem_addr_t a_addr,
	input  logic      a_wr_en,
	input  word_t     a_wdata,
	output word_t     a_rdata,
	// port b, evaluator side, combinational read
	input  mem_addr_t b_addr,
	input  logic      b_wr_en,
	input  word_t     b_wdata,
	output word_t     b_rdata
);

	logic [7:0] mem [mem_depth]; // byte array, no reset

	mem_addr_t a_lo;
	mem_addr_t a_hi;
	mem_addr_t b_lo;
	mem_addr_t b_hi;

	// words live at even addresses, low byte first
	assign a_lo = {a_addr[10:1], 1'b0};
	assign a_hi = {a_addr[10:1], 1'b1};
	assign b_lo = {b_addr[10:1], 1'b0};
	assign b_hi = {b_addr[10:1], 1'b1};

	always_ff @(posedge clock) begin
		if (a_wr_en) begin
			mem[a_lo] <= a_wdata[7:0];
			mem[a_hi] <= a_wdata[15:8];
		end
		if (b_wr_en) begin // placed last so port b wins a clash
			mem[b_lo] <= b_wdata[7:0];
			mem[b_hi] <= b_wdata[15:8];
		end
		a_rdata <= {mem[a_hi], mem[a_lo]}; // old data on read during write
	end

	// evaluator sees data one cycle after it registers b_addr
	assign b_rdata = {mem[b_hi], mem[b_lo]};

endmodule

/* design/best_hop_eval.sv */
`timescale 1ns/10ps

module best_hop_eval
	import cluster_route_pkg::*;
(
	input  logic      clock,
	input  logic      nrst,
	input  logic      start,
	input  word_t     my_cluster_id,
	input  fix_q_t    my_best,
	output mem_addr_t b_addr,
	output logic      b_wr_en,
	output word_t     b_wdata,
	input  word_t     b_rdata,
	output logic      busy,
	output logic      done,
	output word_t     best_hop,
	output word_t     best_neighbor_id,
	output word_t     next_sink,
	output fix_q_t    best_value
);

	eval_state_t state;

	word_t     sink_count;     // known sinks in table
	word_t     neighbor_count;
	word_t     idx;            // current neighbor
	word_t     idx_next;
	word_t     sink_idx;       // position in known sink list
	word_t     better_count;   // entries appended so far
	word_t     nbr_id;         // id of current neighbor
	fix_batt_t batt;           // battery of current neighbor
	fix_q_t    q_val;          // unscaled q of current neighbor

	logic [19:0] batt_x10;
	logic [4:0]  batt_int;
	word_t       hcm_idx;
	logic [31:0] q_product;
	fix_q_t      q_scaled;
	logic        advance;      // current neighbor is finished

	// byte address of word number index in a table
	function automatic mem_addr_t word_addr(input mem_addr_t base, input word_t index);
		return base + {index[9:0], 1'b0};
	endfunction

	assign idx_next = idx + 16'd1;

	// hcm index is the integer part of 10 * battery, clamped to table end
	assign batt_x10 = {4'h0, batt} * 20'd10; // 1.15 times integer
	assign batt_int = batt_x10[19:15];
	assign hcm_idx  = (batt_int >= hcm_length) ? word_t'(hcm_length - 1) : {11'h0, batt_int};

	// 11.5 * 3.13 gives 14.18, keep 11.5 window
	assign q_product = {16'h0, q_val} * {16'h0, b_rdata};
	assign q_scaled  = q_product[28:13];

	// skip conditions and end of sink scan
	always_comb begin
		case (state)
			check_cluster:    advance = (b_rdata != my_cluster_id);
			check_battery:    advance = (b_rdata < battery_threshold); // dead node
			read_neighbor_id: advance = (sink_count == '0);
			scan_sinks:       advance = (sink_idx + 16'd1 == sink_count);
			default:          advance = 1'b0;
		endcase
	end

	always_ff @(posedge clock) begin
		if (!nrst) begin
			state            <= idle;
			busy             <= 1'b0;
			done             <= 1'b0;
			b_wr_en          <= 1'b0;
			b_addr           <= known_sink_count_addr;
			best_hop         <= no_hop;
			best_value       <= worst_value;
			best_neighbor_id <= '0;
			next_sink        <= no_hop;
		end else begin
			case (state)
				idle, finish: begin // done holds until the next start
					if (start) begin
						busy             <= 1'b1;
						done             <= 1'b0;
						best_hop         <= no_hop;
						best_value       <= worst_value;
						best_neighbor_id <= '0;
						next_sink        <= no_hop;
						better_count     <= '0;
						idx              <= '0;
						b_addr           <= known_sink_count_addr;
						state            <= read_sink_count;
					end
				end
				read_sink_count: begin
					sink_count <= b_rdata;
					b_addr     <= neighbor_count_addr;
					state      <= read_neighbor_count;
				end
				read_neighbor_count: begin
					neighbor_count <= b_rdata;
					if (b_rdata == '0) begin // empty table, just report zero
						b_addr  <= better_count_addr;
						b_wdata <= better_count;
						b_wr_en <= 1'b1;
						state   <= write_count;
					end else begin
						b_addr <= cluster_id_base;
						state  <= check_cluster;
					end
				end
				check_cluster: begin // overridden below on a miss
					b_addr <= word_addr(battery_base, idx);
					state  <= check_battery;
				end
				check_battery: begin
					batt   <= b_rdata;
					b_addr <= word_addr(q_value_base, idx);
					state  <= check_q;
				end
				check_q: begin
					q_val <= b_rdata;
					if (b_rdata <= my_best) begin // append index to better list
						b_addr       <= word_addr(better_list_base, better_count);
						b_wdata      <= idx;
						b_wr_en      <= 1'b1;
						better_count <= better_count + 16'd1;
						state        <= write_better;
					end else begin
						b_addr <= word_addr(neighbor_id_base, idx);
						state  <= read_neighbor_id;
					end
				end
				write_better: begin
					b_wr_en <= 1'b0;
					b_addr  <= word_addr(hcm_base, hcm_idx);
					state   <= read_hcm;
				end
				read_hcm: begin
					if (q_scaled < best_value) begin // strict, earlier tie wins
						best_value <= q_scaled;
						best_hop   <= idx;
					end
					b_addr <= word_addr(neighbor_id_base, idx);
					state  <= read_neighbor_id;
				end
				read_neighbor_id: begin
					nbr_id   <= b_rdata;
					sink_idx <= '0;
					b_addr   <= known_sinks_base;
					state    <= scan_sinks;
				end
				scan_sinks: begin
					if (b_rdata == nbr_id)
						next_sink <= idx; // neighbor is a sink
					sink_idx <= sink_idx + 16'd1;
					b_addr   <= word_addr(known_sinks_base, sink_idx + 16'd1);
				end
				read_best_id: begin
					best_neighbor_id <= b_rdata;
					b_addr           <= better_count_addr;
					b_wdata          <= better_count;
					b_wr_en          <= 1'b1;
					state            <= write_count;
				end
				write_count: begin // count lands on this edge
					b_wr_en <= 1'b0;
					busy    <= 1'b0;
					done    <= 1'b1;
					state   <= finish;
				end
				default: state <= idle;
			endcase

			// move on to the next neighbor, or wrap up after the last one
			if (advance) begin
				idx <= idx_next;
				if (idx_next != neighbor_count) begin
					b_addr <= word_addr(cluster_id_base, idx_next);
					state  <= check_cluster;
				end else if (best_hop != no_hop) begin
					b_addr <= word_addr(neighbor_id_base, best_hop);
					state  <= read_best_id;
				end else begin // nothing qualified, id stays cleared
					b_addr  <= better_count_addr;
					b_wdata <= better_count;
					b_wr_en <= 1'b1;
					state   <= write_count;
				end
			end
		end
	end

endmodule

/* design/host_axil_port.sv */
`timescale 1ns/10ps

module host_axil_port
	import cluster_route_pkg::*;
(
	input  logic      clock,
	input  logic      nrst,
	// axi4-lite slave
	input  axi_addr_t awaddr,
	input  logic      awvalid,
	output logic      awready,
	input  axi_data_t wdata,
	input  logic [3:0] wstrb,  // ignored, always a full word
	input  logic      wvalid,
	output logic      wready,
	output logic [1:0] bresp,
	output logic      bvalid,
	input  logic      bready,
	input  axi_addr_t araddr,
	input  logic      arvalid,
	output logic      arready,
	output axi_data_t rdata,
	output logic [1:0] rresp,
	output logic      rvalid,
	input  logic      rready,
	// evaluator control
	output logic      start,
	output word_t     my_cluster_id,
	output fix_q_t    my_best,
	// ram port a
	output mem_addr_t a_addr,
	output logic      a_wr_en,
	output word_t     a_wdata,
	input  word_t     a_rdata,
	// evaluator results
	input  logic      busy,
	input  logic      done,
	input  word_t     best_hop,
	input  fix_q_t    best_value,
	input  word_t     best_neighbor_id,
	input  word_t     next_sink
);

	logic      aw_take;   // address and data both present, can accept
	logic      wr_mem;    // write targets the ram
	logic      rd_mem;    // read targets the ram
	logic      rd_fresh;  // ram word arrives this cycle
	axi_data_t reg_rdata;
	axi_data_t rd_data_q; // held read data

	assign aw_take = awvalid && wvalid && !awready && !bvalid;
	assign wr_mem  = (awaddr < mem_window_end);
	assign rd_mem  = (araddr < mem_window_end);

	assign bresp = 2'b00; // always okay
	assign rresp = 2'b00;

	// port a shared, write cycle has the address
	assign a_addr  = awready ? awaddr[10:0] : araddr[10:0];
	assign a_wr_en = awready && wr_mem;
	assign a_wdata = wdata[15:0]; // upper half dropped

	always_comb begin
		case (araddr)
			reg_cluster_id:       reg_rdata = {16'h0, my_cluster_id};
			reg_my_best:          reg_rdata = {16'h0, my_best};
			reg_status:           reg_rdata = {30'h0, busy, done};
			reg_best_hop:         reg_rdata = {16'h0, best_hop};
			reg_best_value:       reg_rdata = {16'h0, best_value};
			reg_best_neighbor_id: reg_rdata = {16'h0, best_neighbor_id};
			reg_next_sink:        reg_rdata = {16'h0, next_sink};
			default:              reg_rdata = '0; // ctrl and holes
		endcase
	end

	always_ff @(posedge clock) begin
		if (!nrst) begin
			awready       <= 1'b0;
			wready        <= 1'b0;
			bvalid        <= 1'b0;
			arready       <= 1'b0;
			rvalid        <= 1'b0;
			rd_fresh      <= 1'b0;
			start         <= 1'b0;
			my_cluster_id <= '0;
			my_best       <= '0;
		end else begin
			awready <= aw_take; // one cycle pulse, write happens then
			wready  <= aw_take;
			if (awready)
				bvalid <= 1'b1;
			else if (bvalid && bready)
				bvalid <= 1'b0;

			// writes take port a first, read waits a cycle
			arready <= arvalid && !rvalid && !arready && !aw_take;
			if (arready)
				rvalid <= 1'b1;
			else if (rvalid && rready)
				rvalid <= 1'b0;
			rd_fresh <= arready && rd_mem;

			// start only from idle or done
			start <= awready && (awaddr == reg_ctrl) && wdata[0] && !busy;
			if (awready && awaddr == reg_cluster_id)
				my_cluster_id <= wdata[15:0];
			if (awready && awaddr == reg_my_best)
				my_best <= wdata[15:0];
		end
	end

	// read data holding register
	always_ff @(posedge clock) begin
		if (rd_fresh)
			rd_data_q <= {16'h0, a_rdata};
		else if (arready)
			rd_data_q <= reg_rdata;
	end

	// ram word goes straight out on its first cycle, then from the hold
	assign rdata = rd_fresh ? {16'h0, a_rdata} : rd_data_q;

endmodule

/* design/cluster_route_top.sv */
`timescale 1ns/10ps

module cluster_route_top
	import cluster_route_pkg::*;
(
	input  logic       clock,
	input  logic       nrst,
	input  axi_addr_t  awaddr,
	input  logic       awvalid,
	output logic       awready,
	input  axi_data_t  wdata,
	input  logic [3:0] wstrb,
	input  logic       wvalid,
	output logic       wready,
	output logic [1:0] bresp,
	output logic       bvalid,
	input  logic       bready,
	input  axi_addr_t  araddr,
	input  logic       arvalid,
	output logic       arready,
	output axi_data_t  rdata,
	output logic [1:0] rresp,
	output logic       rvalid,
	input  logic       rready
);

	logic      start;
	logic      busy;
	logic      done;
	word_t     my_cluster_id;
	fix_q_t    my_best;
	word_t     best_hop;
	fix_q_t    best_value;
	word_t     best_neighbor_id;
	word_t     next_sink;

	mem_addr_t a_addr;   // host side of ram
	logic      a_wr_en;
	word_t     a_wdata;
	word_t     a_rdata;
	mem_addr_t b_addr;   // evaluator side of ram
	logic      b_wr_en;
	word_t     b_wdata;
	word_t     b_rdata;

	host_axil_port i_host_axil_port (
		.clock            (clock),
		.nrst             (nrst),
		.awaddr           (awaddr),
		.awvalid          (awvalid),
		.awready          (awready),
		.wdata            (wdata),
		.wstrb            (wstrb),
		.wvalid           (wvalid),
		.wready           (wready),
		.bresp            (bresp),
		.bvalid           (bvalid),
		.bready           (bready),
		.araddr           (araddr),
		.arvalid          (arvalid),
		.arready          (arready),
		.rdata            (rdata),
		.rresp            (rresp),
		.rvalid           (rvalid),
		.rready           (rready),
		.start            (start),
		.my_cluster_id    (my_cluster_id),
		.my_best          (my_best),
		.a_addr           (a_addr),
		.a_wr_en          (a_wr_en),
		.a_wdata          (a_wdata),
		.a_rdata          (a_rdata),
		.busy             (busy),
		.done             (done),
		.best_hop         (best_hop),
		.best_value       (best_value),
		.best_neighbor_id (best_neighbor_id),
		.next_sink        (next_sink)
	);

	neighbor_table_ram i_neighbor_table_ram (
		.clock   (clock),
		.a_addr  (a_addr),
		.a_wr_en (a_wr_en),
		.a_wdata (a_wdata),
		.a_rdata (a_rdata),
		.b_addr  (b_addr),
		.b_wr_en (b_wr_en),
		.b_wdata (b_wdata),
		.b_rdata (b_rdata)
	);

	best_hop_eval i_best_hop_eval (
		.clock            (clock),
		.nrst             (nrst),
		.start            (start),
		.my_cluster_id    (my_cluster_id),
		.my_best          (my_best),
		.b_addr           (b_addr),
		.b_wr_en          (b_wr_en),
		.b_wdata          (b_wdata),
		.b_rdata          (b_rdata),
		.busy             (busy),
		.done             (done),
		.best_hop         (best_hop),
		.best_neighbor_id (best_neighbor_id),
		.next_sink        (next_sink),
		.best_value       (best_value)
	);

endmodule

/* verif/clock_gen.sv */
`timescale 1ns/10ps

module clock_gen (
	output logic clock,
	output logic nrst
);

	localparam int half_period  = 10; // 20 ns clock
	localparam int reset_cycles = 3;

	initial begin
		clock = 1'b0;
		forever #(half_period) clock = ~clock;
	end

	initial begin
		nrst = 1'b0; // held low from time zero
		repeat (reset_cycles) @(posedge clock);
		nrst <= 1'b1; // released on an edge, like any sync input
	end

endmodule

/* verif/cluster_route_tb.sv */
`timescale 1ns/10ps

module cluster_route_tb
	import cluster_route_pkg::*;
();

	localparam int n_rows    = 7;
	localparam int max_polls = 500; // status reads before giving up

	logic       clock;
	logic       nrst;
	axi_addr_t  awaddr;
	logic       awvalid;
	logic       awready;
	axi_data_t  wdata;
	logic [3:0] wstrb;
	logic       wvalid;
	logic       wready;
	logic [1:0] bresp;
	logic       bvalid;
	logic       bready;
	axi_addr_t  araddr;
	logic       arvalid;
	logic       arready;
	axi_data_t  rdata;
	logic [1:0] rresp;
	logic       rvalid;
	logic       rready;

	// scenario table with one row per evaluation
	string       tab_name    [n_rows];
	int unsigned tab_n       [n_rows]; // neighbor count
	int unsigned tab_ns      [n_rows]; // known sink count
	word_t       tab_my_cid  [n_rows];
	fix_q_t      tab_my_best [n_rows];
	bit          tab_rand    [n_rows]; // neighbor fields come from the lcg
	word_t       tab_cid     [n_rows][8];
	fix_batt_t   tab_batt    [n_rows][8];
	fix_q_t      tab_q       [n_rows][8];
	word_t       tab_id      [n_rows][8];
	word_t       tab_sink    [n_rows][4];

	// model results for the current row
	word_t  exp_best_hop;
	fix_q_t exp_best_value;
	word_t  exp_best_id;
	word_t  exp_next_sink;
	word_t  exp_list [8];
	int     exp_count;

	int          checks;
	int          errors;
	int          test_errors;
	int          failed_tests;
	logic [31:0] lcg_state = 32'd91;

	clock_gen i_clock_gen (
		.clock (clock),
		.nrst  (nrst)
	);

	cluster_route_top i_cluster_route_top (
		.clock   (clock),
		.nrst    (nrst),
		.awaddr  (awaddr),
		.awvalid (awvalid),
		.awready (awready),
		.wdata   (wdata),
		.wstrb   (wstrb),
		.wvalid  (wvalid),
		.wready  (wready),
		.bresp   (bresp),
		.bvalid  (bvalid),
		.bready  (bready),
		.araddr  (araddr),
		.arvalid (arvalid),
		.arready (arready),
		.rdata   (rdata),
		.rresp   (rresp),
		.rvalid  (rvalid),
		.rready  (rready)
	);

	function automatic word_t lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[30:15]; // upper bits of the state
	endfunction

	// decreasing multipliers with a row offset so each load differs
	function automatic word_t hcm_entry(input int r, input int k);
		return word_t'(32'h6000 - 32'h0400 * k + 32'h0010 * r);
	endfunction

	task automatic load_table();
		tab_name    = '{"basic", "filtering", "tie", "no candidates",
			"random a", "random b", "empty table"};
		tab_n       = '{4, 6, 3, 3, 8, 7, 0};
		tab_ns      = '{2, 3, 2, 1, 4, 3, 2};
		tab_my_cid  = '{16'h3, 16'h5, 16'h1, 16'h1, 16'h0, 16'h0, 16'h0};
		tab_my_best = '{16'h0100, 16'h0400, 16'h0100, 16'h0100, 16'h0200, 16'h0300, 16'h0200};
		tab_rand    = '{0, 0, 0, 0, 1, 1, 1};
		tab_cid[0]  = '{16'h3, 16'h3, 16'h3, 16'h3, 16'h0, 16'h0, 16'h0, 16'h0};
		tab_batt[0] = '{16'h4000, 16'h7FFF, 16'hC000, 16'h6000, 16'h0, 16'h0, 16'h0, 16'h0};
		tab_q[0]    = '{16'h0080, 16'h00C0, 16'h0100, 16'h0040, 16'h0, 16'h0, 16'h0, 16'h0};
		tab_id[0]   = '{16'h11, 16'h22, 16'h33, 16'h44, 16'h0, 16'h0, 16'h0, 16'h0};
		tab_sink[0] = '{16'h22, 16'h99, 16'h0, 16'h0};
		tab_cid[1]  = '{16'h5, 16'h7, 16'h5, 16'h5, 16'h2, 16'h5, 16'h0, 16'h0};
		tab_batt[1] = '{16'h0100, 16'h7000, 16'h0147, 16'h3000, 16'h5000, 16'h1000, 16'h0, 16'h0};
		tab_q[1]    = '{16'h0010, 16'h0008, 16'h0300, 16'h0500, 16'h0020, 16'h0100, 16'h0, 16'h0};
		tab_id[1]   = '{16'h51, 16'h52, 16'h53, 16'h54, 16'h55, 16'h56, 16'h0, 16'h0};
		tab_sink[1] = '{16'h51, 16'h52, 16'h54, 16'h0}; // only 0x54 survives the filters
		tab_cid[2]  = '{16'h1, 16'h1, 16'h1, 16'h0, 16'h0, 16'h0, 16'h0, 16'h0};
		tab_batt[2] = '{16'h4000, 16'h4000, 16'h4000, 16'h0, 16'h0, 16'h0, 16'h0, 16'h0};
		tab_q[2]    = '{16'h0100, 16'h0100, 16'h0100, 16'h0, 16'h0, 16'h0, 16'h0, 16'h0};
		tab_id[2]   = '{16'h7, 16'h8, 16'h9, 16'h0, 16'h0, 16'h0, 16'h0, 16'h0};
		tab_sink[2] = '{16'h8, 16'h9, 16'h0, 16'h0};
		tab_cid[3]  = '{16'h2, 16'h2, 16'h2, 16'h0, 16'h0, 16'h0, 16'h0, 16'h0};
		tab_batt[3] = '{16'h7FFF, 16'h7FFF, 16'h7FFF, 16'h0, 16'h0, 16'h0, 16'h0, 16'h0};
		tab_q[3]    = '{16'h0010, 16'h0010, 16'h0010, 16'h0, 16'h0, 16'h0, 16'h0, 16'h0};
		tab_id[3]   = '{16'hA, 16'hB, 16'hC, 16'h0, 16'h0, 16'h0, 16'h0, 16'h0};
		tab_sink[3] = '{16'hB, 16'h0, 16'h0, 16'h0};
	endtask

	function automatic void fill_random(input int r);
		int i;
		int k;
		for (i = 0; i < 8; i++) begin
			tab_cid[r][i]  = lcg_next() & 16'h0001; // half land in cluster 0
			tab_batt[r][i] = (lcg_next() % 4 == 0) ? (lcg_next() & 16'h01FF) : lcg_next();
			tab_q[r][i]    = lcg_next() & 16'h03FF;
			tab_id[r][i]   = 16'h0100 | (lcg_next() & 16'h00FF);
		end
		for (k = 0; k < 4; k++)
			tab_sink[r][k] = tab_id[r][lcg_next() % 8]; // sinks picked from neighbor ids
	endfunction

	// reference model straight from the routing rules
	function automatic void compute_expected(input int r);
		logic [31:0] product;
		int          hcm_k;
		int          i;
		int          k;
		exp_best_hop   = no_hop;
		exp_best_value = worst_value;
		exp_best_id    = '0;
		exp_next_sink  = no_hop;
		exp_count      = 0;
		for (i = 0; i < tab_n[r]; i++) begin
			if (tab_cid[r][i] != tab_my_cid[r] || tab_batt[r][i] < battery_threshold)
				continue;
			if (tab_q[r][i] <= tab_my_best[r]) begin
				exp_list[exp_count] = word_t'(i);
				exp_count++;
				hcm_k = (int'(tab_batt[r][i]) * 10) / 32768; // integer part of 10 * battery
				if (hcm_k > hcm_length - 1)
					hcm_k = hcm_length - 1;
				product = tab_q[r][i] * hcm_entry(r, hcm_k);
				if (product[28:13] < exp_best_value) begin // first of equals kept
					exp_best_value = product[28:13];
					exp_best_hop   = word_t'(i);
				end
			end
			for (k = 0; k < tab_ns[r]; k++)
				if (tab_sink[r][k] == tab_id[r][i])
					exp_next_sink = word_t'(i);
		end
		if (exp_best_hop != no_hop)
			exp_best_id = tab_id[r][exp_best_hop[2:0]];
	endfunction

	task automatic axi_write(input axi_addr_t addr, input axi_data_t data);
		@(posedge clock);
		awaddr  <= addr;
		wdata   <= data;
		awvalid <= 1'b1;
		wvalid  <= 1'b1;
		do @(negedge clock); while (!awready);
		check_value("wready", wready, 1'b1); // raised together with awready
		@(posedge clock); // write lands on this edge
		awvalid <= 1'b0;
		wvalid  <= 1'b0;
		do @(negedge clock); while (!bvalid);
		check_value("bresp", bresp, 2'b00);
	endtask

	task automatic axi_read(input axi_addr_t addr, output axi_data_t data);
		@(posedge clock);
		araddr  <= addr;
		arvalid <= 1'b1;
		do @(negedge clock); while (!arready);
		@(posedge clock);
		arvalid <= 1'b0;
		do @(negedge clock); while (!rvalid);
		data = rdata; // stable mid cycle
		check_value("rresp", rresp, 2'b00);
	endtask

	task automatic write_word(input int addr, input word_t data);
		axi_write(axi_addr_t'(addr), {16'h0, data});
	endtask

	task automatic check_value(input string name, input axi_data_t got, input axi_data_t exp);
		checks++;
		assert (got === exp)
		else begin
			$display("MISMATCH %s got 0x%h expected 0x%h", name, got, exp);
			test_errors++;
		end
	endtask

	task automatic report_test(input string name);
		if (test_errors == 0) begin
			$display("test %s: ok (%0d checks so far)", name, checks);
		end else begin
			$display("test %s: %0d errors", name, test_errors);
			failed_tests++;
		end
		errors += test_errors;
		test_errors = 0;
	endtask

	task automatic check_register_access();
		axi_data_t rd;
		axi_read(reg_status, rd);
		check_value("status", rd, 32'h0); // idle after reset
		axi_write(reg_cluster_id, 32'h0000_1234);
		axi_read(reg_cluster_id, rd);
		check_value("cluster_id", rd, 32'h0000_1234);
		axi_write(reg_my_best, 32'h0000_BEEF);
		axi_read(reg_my_best, rd);
		check_value("my_best", rd, 32'h0000_BEEF);
		axi_write(13'h07F0, 32'hDEAD_C3C3); // upper half never reaches the ram
		axi_read(13'h07F0, rd);
		check_value("mem[0x7f0]", rd, 32'h0000_C3C3);
		write_word(11'h7FE, 16'hA55A);
		axi_read(13'h07FE, rd);
		check_value("mem[0x7fe]", rd, 32'h0000_A55A);
	endtask

	task automatic run_row(input int r);
		axi_data_t rd;
		int        i;
		int        k;
		int        polls;
		if (tab_rand[r])
			fill_random(r);
		for (k = 0; k < hcm_length; k++)
			write_word(hcm_base + 2 * k, hcm_entry(r, k));
		for (k = 0; k < tab_ns[r]; k++)
			write_word(known_sinks_base + 2 * k, tab_sink[r][k]);
		for (i = 0; i < tab_n[r]; i++) begin
			write_word(neighbor_id_base + 2 * i, tab_id[r][i]);
			write_word(cluster_id_base + 2 * i, tab_cid[r][i]);
			write_word(battery_base + 2 * i, tab_batt[r][i]);
			write_word(q_value_base + 2 * i, tab_q[r][i]);
		end
		write_word(known_sink_count_addr, word_t'(tab_ns[r]));
		write_word(neighbor_count_addr, word_t'(tab_n[r]));
		write_word(better_count_addr, 16'hDEAD); // stale marker the evaluator must overwrite
		axi_write(reg_cluster_id, {16'h0, tab_my_cid[r]});
		axi_write(reg_my_best, {16'h0, tab_my_best[r]});
		axi_write(reg_ctrl, 32'h1);
		axi_read(reg_status, rd);
		check_value("status.done after start", {31'h0, rd[0]}, 32'h0); // start clears done
		polls = 0;
		while (!rd[0] && polls < max_polls) begin
			axi_read(reg_status, rd);
			polls++;
		end
		checks++;
		assert (rd[0])
		else begin
			$display("row %0d: evaluator never raised done after %0d status reads", r, polls);
			test_errors++;
		end
		compute_expected(r);
		check_value("status", rd, 32'h1); // done and not busy
		axi_read(reg_best_hop, rd);
		check_value("best_hop", rd, {16'h0, exp_best_hop});
		axi_read(reg_best_value, rd);
		check_value("best_value", rd, {16'h0, exp_best_value});
		axi_read(reg_best_neighbor_id, rd);
		check_value("best_neighbor_id", rd, {16'h0, exp_best_id});
		axi_read(reg_next_sink, rd);
		check_value("next_sink", rd, {16'h0, exp_next_sink});
		axi_read(axi_addr_t'(better_count_addr), rd);
		check_value("better_count", rd, exp_count);
		for (k = 0; k < exp_count; k++) begin
			axi_read(axi_addr_t'(better_list_base + 2 * k), rd);
			check_value($sformatf("better_list[%0d]", k), rd, {16'h0, exp_list[k]});
		end
	endtask

	// watchdog sized from the number of rows
	initial begin
		#(n_rows * 20000);
		$display("timeout: run still going after %0d ns", n_rows * 20000);
		$display("*** TEST FAILED ***");
		$finish;
	end

	initial begin
		int r;
		awaddr       = '0;
		awvalid      = 1'b0;
		wdata        = '0;
		wstrb        = 4'hF; // full word writes only
		wvalid       = 1'b0;
		bready       = 1'b1; // never back-pressures
		araddr       = '0;
		arvalid      = 1'b0;
		rready       = 1'b1;
		checks       = 0;
		errors       = 0;
		test_errors  = 0;
		failed_tests = 0;
		load_table();
		wait (nrst === 1'b1);
		check_register_access();
		report_test("register and memory access");
		for (r = 0; r < n_rows; r++) begin
			run_row(r);
			report_test(tab_name[r]);
		end
		$display("tests %0d, failed %0d, checks %0d, errors %0d",
			n_rows + 1, failed_tests, checks, errors);
		if (errors == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

/* flist.f */
design/cluster_route_pkg.sv
design/neighbor_table_ram.sv
design/best_hop_eval.sv
design/host_axil_port.sv
design/cluster_route_top.sv
verif/clock_gen.sv
verif/cluster_route_tb.sv

/* run_sim.sh */
#!/bin/bash
# build the cluster route testbench with verilator, run it, judge the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal \
	--top-module cluster_route_tb -f flist.f -o cluster_route_sim \
	&& ./obj_dir/cluster_route_sim > sim.log 2>&1 \
	|| { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -qF "*** TEST PASSED ***" sim.log \
	&& echo "result: pass" \
	|| { echo "result: fail"; exit 1; }
